/* hdl/imem_settings.svh */
/*
  Global sizes for the instruction fetch path. FIFO depth must be a power of
  two of at least 2 and not below the outstanding limit.
*/
`ifndef IMEM_SETTINGS_SVH
`define IMEM_SETTINGS_SVH

// Address and data width, 32-bit RISC-V only
`define IMEM_XLEN 32

// First fetch address, engine still waits for a flush
`define IMEM_RESET_PC 32'h0000_0000

// Parcel buffer entries
`define IMEM_FIFO_DEPTH 4

// Bus transfers in flight at once
`define IMEM_MAX_OUTSTANDING 2

// Number of PMA regions
`define IMEM_PMA_CNT 2

`endif

/* hdl/imem_biu_pkg.sv */
/*
  Bus-side encodings. Protection codes follow the BIU bit layout with
  bit 0 instruction, bit 1 privileged and bit 2 cacheable.
*/
package imem_biu_pkg;

  // Privilege level as driven by the CPU state unit
  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_S = 2'b01,
    PRV_M = 2'b11
  } priv_t;

  // Instruction fetch protection, never cacheable here
  typedef enum logic [2:0] {
    PROT_INSTR_USER = 3'b001,
    PROT_INSTR_PRIV = 3'b011
  } biu_prot_t;

endpackage

/* hdl/imem_fetch_pkg.sv */
/*
  Fetch-side encodings shared by the fetch engine, the parcel FIFO and
  the top level status decode.
*/
package imem_fetch_pkg;

  // Fetch engine state
  typedef enum logic {
    // Issuing fetches
    ST_RUN  = 1'b0,
    // Stopped after a fault, only a flush restarts
    ST_HALT = 1'b1
  } fetch_state_t;

  // Status carried next to each parcel
  typedef enum logic [1:0] {
    PS_OK         = 2'b00,
    PS_MISALIGNED = 2'b01,
    PS_ERROR      = 2'b10
  } parcel_status_t;

endpackage

/* hdl/imem_access_chk.sv */
/*
  One register stage of address checks. Word fetches only, so any set low
  address bit is a misalignment. Lowest matching PMA region wins.
*/
`timescale 1ns/1ps
`include "imem_settings.svh"

module imem_access_chk (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [`IMEM_XLEN-1:0] chk_adr_i,
  input  logic                  chk_vld_i,
  input  logic [`IMEM_XLEN-1:0] pma_base_i [`IMEM_PMA_CNT],
  input  logic [`IMEM_XLEN-1:0] pma_mask_i [`IMEM_PMA_CNT],
  input  logic [`IMEM_PMA_CNT-1:0] pma_exec_i,
  output logic [`IMEM_XLEN-1:0] chk_adr_o,
  output logic                  chk_vld_o,
  output logic                  chk_misaligned_o,
  output logic                  chk_fault_o
);

  logic pma_hit;
  logic pma_exec;
  logic misaligned;

  //////////////////////////////////////////////////////////////////////
  // Combinational checks

  assign misaligned = |chk_adr_i[1:0];

  // Walk downward so the lowest index overrides
  always_comb
  begin
    pma_hit  = 1'b0;
    pma_exec = 1'b0;
    for (int i = `IMEM_PMA_CNT - 1; i >= 0; i--)
    begin
      if ((chk_adr_i & pma_mask_i[i]) == pma_base_i[i])
      begin
        pma_hit  = 1'b1;
        pma_exec = pma_exec_i[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Check register

  // Address follows every cycle
  always_ff @(posedge clk_i)
    chk_adr_o <= chk_adr_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      chk_vld_o        <= 1'b0;
      chk_misaligned_o <= 1'b0;
      chk_fault_o      <= 1'b0;
    end
    else
    begin
      chk_vld_o        <= chk_vld_i;
      chk_misaligned_o <= chk_vld_i & misaligned;
      // No region or region not executable
      chk_fault_o      <= chk_vld_i & (~pma_hit | ~pma_exec);
    end
  end

  // Flags never stand on their own
  a_flags_need_vld: assert property (@(posedge clk_i) disable iff (rst_i)
    (chk_fault_o || chk_misaligned_o) |-> chk_vld_o);

endmodule

/* hdl/imem_fetch_ctrl.sv */
/*
  In-order fetch engine. Relies on the BIU answering in request order with
  one response per accepted strobe. Halts on any fault until a flush.
*/
`timescale 1ns/1ps
`include "imem_settings.svh"

module imem_fetch_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  flush_i,
  input  logic [`IMEM_XLEN-1:0]                 flush_adr_i,
  input  imem_biu_pkg::priv_t                   prv_i,
  input  logic [`IMEM_XLEN-1:0]                 chk_adr_i,
  input  logic                                  chk_vld_i,
  input  logic                                  chk_misaligned_i,
  input  logic                                  chk_fault_i,
  input  logic                                  biu_stb_ack_i,
  input  logic                                  biu_ack_i,
  input  logic                                  biu_err_i,
  input  logic [`IMEM_XLEN-1:0]                 biu_q_i,
  input  logic [$clog2(`IMEM_FIFO_DEPTH+1)-1:0] fifo_cnt_i,
  output logic [`IMEM_XLEN-1:0]                 chk_adr_o,
  output logic                                  chk_vld_o,
  output logic                                  biu_stb_o,
  output logic [`IMEM_XLEN-1:0]                 biu_adri_o,
  output imem_biu_pkg::biu_prot_t               biu_prot_o,
  output logic                                  push_o,
  output logic [`IMEM_XLEN-1:0]                 push_data_o,
  output imem_fetch_pkg::parcel_status_t        push_status_o,
  output logic                                  fifo_clr_o
);

  import imem_biu_pkg::*;
  import imem_fetch_pkg::*;

  localparam int CW = $clog2(`IMEM_MAX_OUTSTANDING + 1);
  localparam int FW = $clog2(`IMEM_FIFO_DEPTH + 1);

  fetch_state_t          state;
  logic [`IMEM_XLEN-1:0] fetch_adr;
  // Live transfers, their data goes to the FIFO
  logic [CW-1:0]         out_cnt;
  // Dead transfers from before a flush or halt
  logic [CW-1:0]         drop_cnt;
  logic                  stb_pend;

  logic                  run;
  logic                  chk_ok;
  logic                  chk_bad;
  logic                  credit;
  logic                  accept;
  logic                  resp;
  logic                  resp_live;
  logic                  resp_dead;
  logic                  live_err;
  logic                  fault_push;
  logic [FW-1:0]         in_flight;
  logic [FW-1:0]         total_nxt;

  //////////////////////////////////////////////////////////////////////
  // Issue side

  assign run     = (state == ST_RUN);
  assign chk_ok  = chk_vld_i & ~chk_misaligned_i & ~chk_fault_i;
  assign chk_bad = chk_vld_i & (chk_misaligned_i | chk_fault_i);

  assign in_flight = FW'(out_cnt) + FW'(drop_cnt);

  // Room on the bus and room in the FIFO for every live transfer
  assign credit = (in_flight < FW'(`IMEM_MAX_OUTSTANDING)) &&
                  (FW'(out_cnt) + fifo_cnt_i < FW'(`IMEM_FIFO_DEPTH));

  // Once raised, the strobe waits for its acknowledge
  assign biu_stb_o  = stb_pend | (run & chk_ok & credit);
  assign biu_adri_o = chk_adr_i;
  assign accept     = biu_stb_o & biu_stb_ack_i;

  assign biu_prot_o = (prv_i == PRV_U) ? PROT_INSTR_USER : PROT_INSTR_PRIV;

  // Next address goes to the checker one cycle early
  assign chk_adr_o = accept ? fetch_adr + `IMEM_XLEN'(4) : fetch_adr;
  assign chk_vld_o = run & ~flush_i;

  //////////////////////////////////////////////////////////////////////
  // Response side

  assign resp      = biu_ack_i | biu_err_i;
  // Dead transfers are always older than live ones
  assign resp_dead = resp & (drop_cnt != '0);
  assign resp_live = resp & (drop_cnt == '0);
  assign live_err  = resp_live & biu_err_i;

  // Checked fault waits until earlier parcels are in
  assign fault_push = run & chk_bad & (out_cnt == '0) &
                      (fifo_cnt_i < FW'(`IMEM_FIFO_DEPTH));

  // Transfers still on the bus after this cycle
  assign total_nxt = in_flight + FW'(accept) - FW'(resp);

  assign fifo_clr_o  = flush_i;
  assign push_o      = ~flush_i & (resp_live | fault_push);
  // Fault parcels carry the offending address
  assign push_data_o = resp_live ? biu_q_i : chk_adr_i;

  always_comb
  begin
    if (resp_live)
      push_status_o = biu_err_i ? PS_ERROR : PS_OK;
    else
      push_status_o = chk_misaligned_i ? PS_MISALIGNED : PS_ERROR;
  end

  //////////////////////////////////////////////////////////////////////
  // State, address and counters

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state     <= ST_HALT;
      fetch_adr <= `IMEM_RESET_PC;
      out_cnt   <= '0;
      drop_cnt  <= '0;
      stb_pend  <= 1'b0;
    end
    else if (flush_i)
    begin
      // Everything in flight becomes dead
      state     <= ST_RUN;
      fetch_adr <= flush_adr_i;
      out_cnt   <= '0;
      drop_cnt  <= CW'(total_nxt);
      stb_pend  <= 1'b0;
    end
    else
    begin
      stb_pend <= biu_stb_o & ~biu_stb_ack_i;
      if (accept)
        fetch_adr <= fetch_adr + `IMEM_XLEN'(4);

      if (live_err)
      begin
        // Younger transfers must not yield parcels
        state    <= ST_HALT;
        out_cnt  <= '0;
        drop_cnt <= CW'(total_nxt);
      end
      else
      begin
        if (fault_push)
          state <= ST_HALT;
        // Accepts after a halt belong to the dead count
        out_cnt  <= out_cnt + CW'(accept & run) - CW'(resp_live);
        drop_cnt <= drop_cnt + CW'(accept & ~run) - CW'(resp_dead);
      end
    end
  end

  a_max_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    in_flight <= FW'(`IMEM_MAX_OUTSTANDING));

  a_adr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    biu_stb_o && !biu_stb_ack_i && !flush_i |=> $stable(biu_adri_o));

endmodule

/* hdl/imem_parcel_fifo.sv */
/*
  Circular parcel buffer. DEPTH must be a power of two, 2 or more.
  Clear wins over push and pop in the same cycle.
*/
`timescale 1ns/1ps
`include "imem_settings.svh"

module imem_parcel_fifo #(
  parameter int DEPTH = `IMEM_FIFO_DEPTH
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           clr_i,
  input  logic                           push_i,
  input  logic [`IMEM_XLEN-1:0]          push_data_i,
  input  imem_fetch_pkg::parcel_status_t push_status_i,
  input  logic                           pop_i,
  output logic [`IMEM_XLEN-1:0]          data_o,
  output imem_fetch_pkg::parcel_status_t status_o,
  output logic                           valid_o,
  output logic [$clog2(DEPTH+1)-1:0]     cnt_o
);

  import imem_fetch_pkg::*;

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  logic [`IMEM_XLEN-1:0] data_mem   [DEPTH];
  parcel_status_t        status_mem [DEPTH];
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic                  do_push;
  logic                  do_pop;

  assign do_push = push_i & ~clr_i;
  // Pop only what is there
  assign do_pop  = pop_i & valid_o & ~clr_i;

  assign valid_o  = (cnt_o != '0);
  assign data_o   = data_mem[rd_ptr];
  assign status_o = status_mem[rd_ptr];

  // Storage
  always_ff @(posedge clk_i)
  begin
    if (do_push)
    begin
      data_mem[wr_ptr]   <= push_data_i;
      status_mem[wr_ptr] <= push_status_i;
    end
  end

  // Pointers wrap by their width
  always_ff @(posedge clk_i)
  begin
    if (rst_i || clr_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt_o  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + AW'(1);
      if (do_pop)
        rd_ptr <= rd_ptr + AW'(1);
      cnt_o <= cnt_o + CW'(do_push) - CW'(do_pop);
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i && !clr_i |-> cnt_o != CW'(DEPTH));

endmodule

/* hdl/imem_ctrl.sv */
/*
  Instruction fetch controller without cache, MMU or PMP. Word parcels
  only. Flags on the parcel outputs are low while no parcel is valid.
*/
`timescale 1ns/1ps
`include "imem_settings.svh"

module imem_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // CPU side
  input  logic                     mem_req_i,
  input  logic                     mem_flush_i,
  input  logic [`IMEM_XLEN-1:0]    mem_adr_i,
  input  imem_biu_pkg::priv_t      st_prv_i,
  output logic [`IMEM_XLEN-1:0]    parcel_o,
  output logic                     parcel_valid_o,
  output logic                     mem_misaligned_o,
  output logic                     mem_error_o,
  // PMA configuration
  input  logic [`IMEM_XLEN-1:0]    pma_base_i [`IMEM_PMA_CNT],
  input  logic [`IMEM_XLEN-1:0]    pma_mask_i [`IMEM_PMA_CNT],
  input  logic [`IMEM_PMA_CNT-1:0] pma_exec_i,
  // BIU side
  output logic                     biu_stb_o,
  input  logic                     biu_stb_ack_i,
  output logic [`IMEM_XLEN-1:0]    biu_adri_o,
  output imem_biu_pkg::biu_prot_t  biu_prot_o,
  input  logic [`IMEM_XLEN-1:0]    biu_q_i,
  input  logic                     biu_ack_i,
  input  logic                     biu_err_i
);

  import imem_fetch_pkg::*;

  // Fetch engine to checker
  logic [`IMEM_XLEN-1:0] chk_adr;
  logic                  chk_vld;
  // Checker back to fetch engine
  logic [`IMEM_XLEN-1:0] chk_adr_q;
  logic                  chk_vld_q;
  logic                  chk_misaligned;
  logic                  chk_fault;

  logic                  push;
  logic [`IMEM_XLEN-1:0] push_data;
  parcel_status_t        push_status;
  logic                  fifo_clr;
  logic [$clog2(`IMEM_FIFO_DEPTH+1)-1:0] fifo_cnt;
  parcel_status_t        fifo_status;
  logic                  pop;

  // CPU takes the head parcel when it asks
  assign pop = mem_req_i & parcel_valid_o;

  assign mem_misaligned_o = parcel_valid_o & (fifo_status == PS_MISALIGNED);
  assign mem_error_o      = parcel_valid_o & (fifo_status == PS_ERROR);

  imem_access_chk access_chk_inst (
    .clk_i            ( clk_i          ),
    .rst_i            ( rst_i          ),
    .chk_adr_i        ( chk_adr        ),
    .chk_vld_i        ( chk_vld        ),
    .pma_base_i       ( pma_base_i     ),
    .pma_mask_i       ( pma_mask_i     ),
    .pma_exec_i       ( pma_exec_i     ),
    .chk_adr_o        ( chk_adr_q      ),
    .chk_vld_o        ( chk_vld_q      ),
    .chk_misaligned_o ( chk_misaligned ),
    .chk_fault_o      ( chk_fault      )
  );

  imem_fetch_ctrl fetch_ctrl_inst (
    .clk_i            ( clk_i          ),
    .rst_i            ( rst_i          ),
    .flush_i          ( mem_flush_i    ),
    .flush_adr_i      ( mem_adr_i      ),
    .prv_i            ( st_prv_i       ),
    .chk_adr_i        ( chk_adr_q      ),
    .chk_vld_i        ( chk_vld_q      ),
    .chk_misaligned_i ( chk_misaligned ),
    .chk_fault_i      ( chk_fault      ),
    .biu_stb_ack_i    ( biu_stb_ack_i  ),
    .biu_ack_i        ( biu_ack_i      ),
    .biu_err_i        ( biu_err_i      ),
    .biu_q_i          ( biu_q_i        ),
    .fifo_cnt_i       ( fifo_cnt       ),
    .chk_adr_o        ( chk_adr        ),
    .chk_vld_o        ( chk_vld        ),
    .biu_stb_o        ( biu_stb_o      ),
    .biu_adri_o       ( biu_adri_o     ),
    .biu_prot_o       ( biu_prot_o     ),
    .push_o           ( push           ),
    .push_data_o      ( push_data      ),
    .push_status_o    ( push_status    ),
    .fifo_clr_o       ( fifo_clr       )
  );

  imem_parcel_fifo #(
    .DEPTH ( `IMEM_FIFO_DEPTH )
  ) parcel_fifo_inst (
    .clk_i         ( clk_i          ),
    .rst_i         ( rst_i          ),
    .clr_i         ( fifo_clr       ),
    .push_i        ( push           ),
    .push_data_i   ( push_data      ),
    .push_status_i ( push_status    ),
    .pop_i         ( pop            ),
    .data_o        ( parcel_o       ),
    .status_o      ( fifo_status    ),
    .valid_o       ( parcel_valid_o ),
    .cnt_o         ( fifo_cnt       )
  );

endmodule

/* verification/imem_biu_model.sv */
/*
  BIU responder for simulation. Accepts after 0 to 3 cycles, answers in order
  after 1 to 4 cycles. Data is the address XOR a key; one window errors.
*/
`timescale 1ns/1ps
`include "imem_settings.svh"

module imem_biu_model (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  biu_stb_i,
  input  logic [`IMEM_XLEN-1:0] biu_adri_i,
  output logic                  biu_stb_ack_o = 1'b0,
  output logic [`IMEM_XLEN-1:0] biu_q_o = '0,
  output logic                  biu_ack_o = 1'b0,
  output logic                  biu_err_o = 1'b0
);

  localparam logic [`IMEM_XLEN-1:0] DATA_KEY = 32'h5a5a_0000;
  localparam logic [`IMEM_XLEN-1:0] ERR_LO   = 32'h0000_3000;
  localparam logic [`IMEM_XLEN-1:0] ERR_HI   = 32'h0000_30ff;

  // Accepted addresses, oldest first
  logic [`IMEM_XLEN-1:0] resp_q [$];
  logic [`IMEM_XLEN-1:0] resp_adr;
  int unsigned           acc_wait;
  int unsigned           resp_wait;

  always @(posedge clk_i)
  begin
    if (rst_i)
    begin
      biu_stb_ack_o <= 1'b0;
      biu_ack_o     <= 1'b0;
      biu_err_o     <= 1'b0;
      acc_wait       = 0;
      resp_wait     <= 0;
      resp_q.delete();
    end
    else
    begin
      ////////////////////////////////////////////////////////////////////
      // Response side, served before this edge's accept is queued
      biu_ack_o <= 1'b0;
      biu_err_o <= 1'b0;
      if (resp_q.size() != 0)
      begin
        if (resp_wait == 0)
        begin
          resp_adr = resp_q.pop_front();
          biu_q_o <= resp_adr ^ DATA_KEY;
          if (resp_adr >= ERR_LO && resp_adr <= ERR_HI)
            biu_err_o <= 1'b1;
          else
            biu_ack_o <= 1'b1;
          resp_wait <= $urandom_range(3, 0);
        end
        else
          resp_wait <= resp_wait - 1;
      end

      ////////////////////////////////////////////////////////////////////
      // Request side, ack acts as a ready level
      if (biu_stb_i && biu_stb_ack_o)
      begin
        resp_q.push_back(biu_adri_i);
        acc_wait = $urandom_range(3, 0);
        biu_stb_ack_o <= (acc_wait == 0);
      end
      else if (biu_stb_i && !biu_stb_ack_o)
      begin
        // Count only cycles with a waiting strobe
        if (acc_wait <= 1)
          biu_stb_ack_o <= 1'b1;
        else
          acc_wait = acc_wait - 1;
      end
    end
  end

endmodule

/* verification/imem_ctrl_tb.sv */
/*
  Testbench for the fetch controller. PMA region 0 (low 64 KiB) executes,
  region 1 does not. Checks are concurrent assertions on a next-address model.
*/
`timescale 1ns/1ps
`include "imem_settings.svh"

module imem_ctrl_tb;

  import imem_biu_pkg::*;

  localparam int                    CLK_PERIOD   = 8;
  localparam int                    NUM_PHASES   = 6;
  localparam int                    PHASE_CYCLES = 2500;
  // Cycles without a pop after which the FIFO must be full
  localparam int                    IDLE_LIMIT   = 48;
  localparam logic [31:0]           SEED         = 32'h373c;
  localparam logic [`IMEM_XLEN-1:0] DATA_KEY     = 32'h5a5a_0000;
  localparam logic [`IMEM_XLEN-1:0] EXEC_MASK    = 32'hffff_0000;
  localparam logic [`IMEM_XLEN-1:0] ERR_LO       = 32'h0000_3000;
  localparam logic [`IMEM_XLEN-1:0] ERR_HI       = 32'h0000_30ff;

  logic                     clk_i;
  logic                     rst_i;
  logic                     mem_req_i;
  logic                     mem_flush_i;
  logic [`IMEM_XLEN-1:0]    mem_adr_i;
  priv_t                    st_prv_i;
  logic [`IMEM_XLEN-1:0]    parcel_o;
  logic                     parcel_valid_o;
  logic                     mem_misaligned_o;
  logic                     mem_error_o;
  logic [`IMEM_XLEN-1:0]    pma_base [`IMEM_PMA_CNT];
  logic [`IMEM_XLEN-1:0]    pma_mask [`IMEM_PMA_CNT];
  logic [`IMEM_PMA_CNT-1:0] pma_exec;
  logic                     biu_stb_o;
  logic                     biu_stb_ack_i;
  logic [`IMEM_XLEN-1:0]    biu_adri_o;
  biu_prot_t                biu_prot_o;
  logic [`IMEM_XLEN-1:0]    biu_q_i;
  logic                     biu_ack_i;
  logic                     biu_err_i;

  // Reference model state
  logic [`IMEM_XLEN-1:0]    exp_adr;
  logic                     halted;
  logic                     chk_halted;
  logic                     started;
  logic                     take;
  int                       pop_cnt;
  int                       idle_cnt;

  imem_ctrl UUT (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .mem_req_i        ( mem_req_i        ),
    .mem_flush_i      ( mem_flush_i      ),
    .mem_adr_i        ( mem_adr_i        ),
    .st_prv_i         ( st_prv_i         ),
    .parcel_o         ( parcel_o         ),
    .parcel_valid_o   ( parcel_valid_o   ),
    .mem_misaligned_o ( mem_misaligned_o ),
    .mem_error_o      ( mem_error_o      ),
    .pma_base_i       ( pma_base         ),
    .pma_mask_i       ( pma_mask         ),
    .pma_exec_i       ( pma_exec         ),
    .biu_stb_o        ( biu_stb_o        ),
    .biu_stb_ack_i    ( biu_stb_ack_i    ),
    .biu_adri_o       ( biu_adri_o       ),
    .biu_prot_o       ( biu_prot_o       ),
    .biu_q_i          ( biu_q_i          ),
    .biu_ack_i        ( biu_ack_i        ),
    .biu_err_i        ( biu_err_i        )
  );

  imem_biu_model biu_model_inst (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .biu_stb_i     ( biu_stb_o     ),
    .biu_adri_i    ( biu_adri_o    ),
    .biu_stb_ack_o ( biu_stb_ack_i ),
    .biu_q_o       ( biu_q_i       ),
    .biu_ack_o     ( biu_ack_i     ),
    .biu_err_o     ( biu_err_i     )
  );

  ////////////////////////////////////////////////////////////////////////
  // Expected behavior from the address rules

  function automatic logic in_exec_region(input logic [`IMEM_XLEN-1:0] a);
    return (a & EXEC_MASK) == '0;
  endfunction

  function automatic logic misaligned_at(input logic [`IMEM_XLEN-1:0] a);
    return a[1:0] != 2'b00;
  endfunction

  // Misalignment wins over PMA and bus faults
  function automatic logic error_expected(input logic [`IMEM_XLEN-1:0] a);
    return !misaligned_at(a) && (!in_exec_region(a) || (a >= ERR_LO && a <= ERR_HI));
  endfunction

  function automatic biu_prot_t prot_for_level(input priv_t p);
    return (p == PRV_U) ? PROT_INSTR_USER : PROT_INSTR_PRIV;
  endfunction

  function automatic priv_t random_level(input int unsigned r);
    case (r)
      0:       return PRV_U;
      1:       return PRV_S;
      default: return PRV_M;
    endcase
  endfunction

  assign take = mem_req_i && parcel_valid_o && !mem_flush_i;

  // Next address the CPU should see
  always @(posedge clk_i)
  begin
    if (rst_i)
    begin
      exp_adr    <= '0;
      halted     <= 1'b0;
      chk_halted <= 1'b0;
      started    <= 1'b0;
      pop_cnt    <= 0;
    end
    else if (mem_flush_i)
    begin
      exp_adr    <= mem_adr_i;
      halted     <= 1'b0;
      chk_halted <= 1'b0;
      started    <= 1'b1;
    end
    else if (take)
    begin
      exp_adr <= exp_adr + 32'd4;
      pop_cnt <= pop_cnt + 1;
      // Faulting parcel is the last one
      if (misaligned_at(exp_adr) || error_expected(exp_adr))
        halted <= 1'b1;
      if (misaligned_at(exp_adr) || !in_exec_region(exp_adr))
        chk_halted <= 1'b1;
    end
  end

  // Run of cycles without a pop request
  always @(posedge clk_i)
  begin
    if (rst_i || mem_flush_i || mem_req_i)
      idle_cnt <= 0;
    else if (idle_cnt < 1000)
      idle_cnt <= idle_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////////
  // Checks

  task automatic stop_on_error();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  a_parcel_data: assert property (@(posedge clk_i) disable iff (rst_i)
    take && !misaligned_at(exp_adr) && !error_expected(exp_adr)
    |-> parcel_o == (exp_adr ^ DATA_KEY))
  else
  begin
    $display("ERROR %0t parcel_o got %h expected %h", $time, $sampled(parcel_o),
             $sampled(exp_adr) ^ DATA_KEY);
    stop_on_error();
  end

  a_misaligned_flag: assert property (@(posedge clk_i) disable iff (rst_i)
    take |-> mem_misaligned_o == misaligned_at(exp_adr))
  else
  begin
    $display("ERROR %0t mem_misaligned_o got %b expected %b", $time,
             $sampled(mem_misaligned_o), misaligned_at($sampled(exp_adr)));
    stop_on_error();
  end

  a_error_flag: assert property (@(posedge clk_i) disable iff (rst_i)
    take |-> mem_error_o == error_expected(exp_adr))
  else
  begin
    $display("ERROR %0t mem_error_o got %b expected %b", $time,
             $sampled(mem_error_o), error_expected($sampled(exp_adr)));
    stop_on_error();
  end

  a_prot: assert property (@(posedge clk_i) disable iff (rst_i)
    biu_prot_o == prot_for_level(st_prv_i))
  else
  begin
    $display("ERROR %0t biu_prot_o got %0d expected %0d", $time,
             $sampled(biu_prot_o), prot_for_level($sampled(st_prv_i)));
    stop_on_error();
  end

  a_quiet_after_fault: assert property (@(posedge clk_i) disable iff (rst_i)
    halted |-> !parcel_valid_o)
  else
  begin
    $display("A parcel was offered after a faulting parcel at %0t", $time);
    stop_on_error();
  end

  a_no_stb_after_check: assert property (@(posedge clk_i) disable iff (rst_i)
    chk_halted |-> !biu_stb_o)
  else
  begin
    $display("A bus strobe came after a check fault at %0t", $time);
    stop_on_error();
  end

  a_stb_target: assert property (@(posedge clk_i) disable iff (rst_i)
    biu_stb_o |-> !misaligned_at(biu_adri_o) && in_exec_region(biu_adri_o))
  else
  begin
    $display("A bus strobe went to bad address %h at %0t", $sampled(biu_adri_o), $time);
    stop_on_error();
  end

  a_flush_gap: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_flush_i |=> !biu_stb_o)
  else
  begin
    $display("A bus strobe came one cycle after a flush at %0t", $time);
    stop_on_error();
  end

  a_reset_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    !started |-> !biu_stb_o && !parcel_valid_o)
  else
  begin
    $display("Strobe or parcel seen before the first flush at %0t", $time);
    stop_on_error();
  end

  a_backpressure: assert property (@(posedge clk_i) disable iff (rst_i)
    idle_cnt >= IDLE_LIMIT |-> !biu_stb_o)
  else
  begin
    $display("Bus strobes went on while the CPU took no parcels at %0t", $time);
    stop_on_error();
  end

  ////////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  // Starts on a clock edge and returns one edge later
  task automatic flush_now(input logic [`IMEM_XLEN-1:0] adr);
    mem_req_i   <= 1'b0;
    mem_flush_i <= 1'b1;
    mem_adr_i   <= adr;
    @(posedge clk_i);
    mem_flush_i <= 1'b0;
  endtask

  task automatic pop_parcels(input int n, input int pct);
    int target;
    target = pop_cnt + n;
    while (pop_cnt < target)
    begin
      mem_req_i <= (int'($urandom_range(99, 0)) < pct);
      @(posedge clk_i);
    end
    mem_req_i <= 1'b0;
  endtask

  task automatic drain_to_fault(input int pct);
    while (!halted)
    begin
      mem_req_i <= (int'($urandom_range(99, 0)) < pct);
      @(posedge clk_i);
    end
    mem_req_i <= 1'b0;
    idle_cycles(40);
  endtask

  // CPU stalls while privilege keeps moving
  task automatic hold_off(input int n);
    mem_req_i <= 1'b0;
    repeat (n)
    begin
      st_prv_i <= random_level($urandom_range(2, 0));
      @(posedge clk_i);
    end
  endtask

  // Returns on the edge that accepts a transfer
  task automatic wait_accept();
    mem_req_i <= 1'b1;
    @(posedge clk_i);
    while (!(biu_stb_o && biu_stb_ack_i))
      @(posedge clk_i);
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial
  begin
    repeat (NUM_PHASES * PHASE_CYCLES) @(posedge clk_i);
    $display("Timeout: the test phases did not finish in time");
    stop_on_error();
  end

  initial
  begin
    void'($urandom(SEED));
    rst_i       = 1'b1;
    mem_req_i   = 1'b0;
    mem_flush_i = 1'b0;
    mem_adr_i   = '0;
    st_prv_i    = PRV_M;
    pma_base[0] = 32'h0000_0000;
    pma_mask[0] = EXEC_MASK;
    pma_base[1] = 32'h0001_0000;
    pma_mask[1] = EXEC_MASK;
    pma_exec    = 2'b01;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    idle_cycles(10);

    // Aligned stream
    flush_now(32'h0000_0100);
    pop_parcels(40, 70);
    // Misaligned target
    flush_now(32'h0000_0201);
    drain_to_fault(80);
    // Non-executable region
    flush_now(32'h0001_0040);
    drain_to_fault(80);
    // Stream runs into the bus error window
    flush_now(32'h0000_2f80);
    drain_to_fault(60);
    // Long stalls with privilege changes
    flush_now(32'h0000_0400);
    repeat (4)
    begin
      hold_off(72);
      pop_parcels(10, 100);
    end
    // Flushes with transfers in flight
    flush_now(32'h0000_0800);
    pop_parcels(6, 60);
    wait_accept();
    flush_now(32'h0000_1000);
    pop_parcels(30, 60);
    wait_accept();
    flush_now(32'h0000_1804);
    pop_parcels(30, 50);
    wait_accept();
    flush_now(32'h0000_2400);
    pop_parcels(30, 80);
    idle_cycles(20);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* flist.f */
+incdir+hdl
hdl/imem_biu_pkg.sv
hdl/imem_fetch_pkg.sv
hdl/imem_access_chk.sv
hdl/imem_fetch_ctrl.sv
hdl/imem_parcel_fifo.sv
hdl/imem_ctrl.sv
verification/imem_biu_model.sv
verification/imem_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module imem_ctrl_tb \
  -f flist.f -o imem_ctrl_sim \
  && ./obj_dir/imem_ctrl_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }

cat sim.log
grep -q '\*\*\* PASSED \*\*\*' sim.log \
  && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }
